//--- Makefile
VERILATOR := verilator
TOP       := waterfall_tb
FILELIST  := all.f
FLAGS     := --binary --timing --assert -j 0
PASS_MSG  := All tests passed!
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
src/waterfall_pkg.sv
src/video_timing.sv
src/column_framebuffer.sv
src/waterfall_regs.sv
src/dual_waterfall.sv
src/waterfall_top.sv
tb/waterfall_properties.sv
tb/waterfall_checker.sv
tb/waterfall_tb.sv

//--- src/column_framebuffer.sv
`timescale 1ns/1ps

module column_framebuffer
    import waterfall_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic                clk_disp,
    input  logic                rst_n,
    input  sample_t             sink,
    input  scan_pos_t           scan,
    output logic [SAMPLE_W-1:0] line_data
);

    // the ring holds more than one screen of samples, so up to 3*DEPTH pushes
    // during a frame land outside the window that the frame is reading.
    localparam int RING = 4 * DEPTH;
    localparam int PTR_W = $clog2(RING);

    logic [SAMPLE_W-1:0] mem [RING];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    base;
    logic [PTR_W-1:0]    rd_base;
    logic [PTR_W-1:0]    line_idx;
    logic [PTR_W:0]      rd_sum;
    logic [PTR_W-1:0]    rd_addr;

    always_ff @(posedge clk_disp) begin
        if (!rst_n) begin
            for (int i = 0; i < RING; i++) begin
                mem[i] <= '0; // empty lines read as zero.
            end
        end else if (sink.valid) begin
            mem[wr_ptr] <= sink.data;
        end
    end

    always_ff @(posedge clk_disp) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            base <= '0;
        end else begin
            if (sink.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(RING - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (is_frame_start(scan)) begin
                base <= wr_ptr;
            end
        end
    end

    // the frame-start cycle already reads with the new base.
    assign rd_base = is_frame_start(scan) ? wr_ptr : base;
    assign line_idx = (scan.v < POS_W'(DEPTH)) ? scan.v[PTR_W-1:0] : '0;

    // line 0 is the sample DEPTH places behind the latched write pointer.
    assign rd_sum = {1'b0, rd_base} + (PTR_W + 1)'(RING - DEPTH) + {1'b0, line_idx};
    assign rd_addr = (rd_sum >= (PTR_W + 1)'(RING)) ? PTR_W'(rd_sum - (PTR_W + 1)'(RING))
                                                     : rd_sum[PTR_W-1:0];

    always_ff @(posedge clk_disp) begin
        line_data <= mem[rd_addr];
    end

endmodule

//--- src/dual_waterfall.sv
`timescale 1ns/1ps

module dual_waterfall
    import waterfall_pkg::*;
(
    input  logic                clk_disp,
    input  logic                rst_n,
    input  scan_pos_t           scan,
    input  disp_cfg_t           cfg,
    input  logic [SAMPLE_W-1:0] high_data,
    input  logic [SAMPLE_W-1:0] low_data,
    output rgb_pixel_t          pixel,
    output scan_pos_t           pixel_pos
);

    disp_cfg_t  cfg_q;
    scan_pos_t  scan_d;
    rgb_pixel_t next_pixel;
    logic       in_high;
    logic       in_low;

    function automatic logic in_span(input span_t span, input logic [POS_W-1:0] h);
        return (h >= span.left) && (h < span.right);
    endfunction

    // upper byte to red and lower byte to blue, green stays dark.
    function automatic rgb_pixel_t paint(input logic [SAMPLE_W-1:0] data);
        return '{red: data[SAMPLE_W-1 -: 8], green: 8'h00, blue: data[7:0]};
    endfunction

    always_ff @(posedge clk_disp) begin
        if (!rst_n) begin
            cfg_q <= CFG_RESET;
        end else if (is_frame_start(scan)) begin
            cfg_q <= cfg; // settings hold for the whole frame.
        end
    end

    // scan_d lines up with the framebuffer data, which lags the scan by one cycle.
    assign in_high = in_span(cfg_q.high_span, scan_d.h);
    assign in_low = in_span(cfg_q.low_span, scan_d.h);

    always_comb begin
        if (!scan_d.active || !cfg_q.enable) begin
            next_pixel = '0;
        end else if (in_high) begin
            next_pixel = paint(high_data); // high band wins where the spans overlap.
        end else if (in_low) begin
            next_pixel = paint(low_data);
        end else begin
            next_pixel = cfg_q.background;
        end
    end

    always_ff @(posedge clk_disp) begin
        if (!rst_n) begin
            scan_d <= '0;
            pixel_pos <= '0;
            pixel <= '0;
        end else begin
            scan_d <= scan;
            pixel_pos <= scan_d;
            pixel <= next_pixel;
        end
    end

endmodule

//--- src/video_timing.sv
`timescale 1ns/1ps

module video_timing
    import waterfall_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  logic      clk_disp,
    input  logic      rst_n,
    output scan_pos_t scan
);

    logic [POS_W-1:0] h_cnt;
    logic [POS_W-1:0] v_cnt;
    logic             h_last;
    logic             v_last;
    logic             h_visible;
    logic             v_visible;

    assign h_last = (h_cnt == POS_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == POS_W'(V_TOTAL - 1));

    always_ff @(posedge clk_disp) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1; // v steps once per full line.
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // the active flag follows straight from the counters, so it lines up with h and v.
    assign h_visible = (h_cnt < POS_W'(H_ACTIVE));
    assign v_visible = (v_cnt < POS_W'(V_ACTIVE));

    assign scan = '{
        h:      h_cnt,
        v:      v_cnt,
        active: h_visible && v_visible
    };

endmodule

//--- src/waterfall_pkg.sv
package waterfall_pkg;

    localparam int POS_W = 10;
    localparam int SAMPLE_W = 16;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_pixel_t;

    typedef struct packed {
        logic [POS_W-1:0] h;
        logic [POS_W-1:0] v;
        logic             active;
    } scan_pos_t;

    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] data;
    } sample_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr; // word index.
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // h is inside when left <= h < right.
    typedef struct packed {
        logic [POS_W-1:0] left;
        logic [POS_W-1:0] right;
    } span_t;

    typedef struct packed {
        logic [7:0] unused;
        rgb_pixel_t rgb;
    } color_view_t;

    typedef struct packed {
        logic [11:0] unused;
        span_t       bounds;
    } span_view_t;

    // the register address picks which view of the bus word is meaningful.
    typedef union packed {
        color_view_t color;
        span_view_t  span;
    } reg_word_u;

    typedef struct packed {
        rgb_pixel_t background;
        span_t      high_span;
        span_t      low_span;
        logic       enable;
    } disp_cfg_t;

    localparam logic [3:0] REG_BG = 4'd0;
    localparam logic [3:0] REG_HIGH_SPAN = 4'd1;
    localparam logic [3:0] REG_LOW_SPAN = 4'd2;
    localparam logic [3:0] REG_CTRL = 4'd3;

    localparam disp_cfg_t CFG_RESET = '{
        background: '{red: 8'h00, green: 8'hf5, blue: 8'h00},
        high_span:  '{left: 10'd96, right: 10'd192},
        low_span:   '{left: 10'd288, right: 10'd384},
        enable:     1'b1
    };

    function automatic logic is_frame_start(input scan_pos_t pos);
        return (pos.h == '0) && (pos.v == '0);
    endfunction

endpackage

//--- src/waterfall_regs.sv
`timescale 1ns/1ps

module waterfall_regs
    import waterfall_pkg::*;
(
    input  logic      clk_disp,
    input  logic      rst_n,
    input  wb_req_t   wb_i,
    output wb_rsp_t   wb_o,
    output disp_cfg_t cfg
);

    logic        req;
    logic        accept;
    logic        ack_q;
    logic [31:0] rd_dat_q;
    reg_word_u   wr_word;
    reg_word_u   rd_word;
    disp_cfg_t   cfg_q;

    assign req = wb_i.cyc && wb_i.stb;
    assign accept = req && !ack_q; // the cycle with ack high closes the request.
    assign wr_word = wb_i.dat;

    always_comb begin
        rd_word = '0;
        case (wb_i.adr)
            REG_BG: begin
                rd_word.color.rgb = cfg_q.background;
            end
            REG_HIGH_SPAN: begin
                rd_word.span.bounds = cfg_q.high_span;
            end
            REG_LOW_SPAN: begin
                rd_word.span.bounds = cfg_q.low_span;
            end
            REG_CTRL: begin
                rd_word = {31'b0, cfg_q.enable};
            end
            default: begin
                rd_word = '0; // unmapped words read zero.
            end
        endcase
    end

    // a write is taken on the edge that raises ack, so the register holds it in the ack cycle.
    always_ff @(posedge clk_disp) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            cfg_q <= CFG_RESET;
        end else begin
            ack_q <= accept;
            if (accept && wb_i.we) begin
                case (wb_i.adr)
                    REG_BG:        cfg_q.background <= wr_word.color.rgb;
                    REG_HIGH_SPAN: cfg_q.high_span <= wr_word.span.bounds;
                    REG_LOW_SPAN:  cfg_q.low_span <= wr_word.span.bounds;
                    REG_CTRL:      cfg_q.enable <= wb_i.dat[0];
                    default:       ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_disp) begin
        if (accept) begin
            rd_dat_q <= rd_word;
        end
    end

    assign wb_o = '{dat: rd_dat_q, ack: ack_q};
    assign cfg = cfg_q;

endmodule

//--- src/waterfall_top.sv
`timescale 1ns/1ps

module waterfall_top
    import waterfall_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  logic       clk_disp,
    input  logic       rst_n,
    input  sample_t    high_sample,
    input  sample_t    low_sample,
    input  wb_req_t    wb_i,
    output wb_rsp_t    wb_o,
    output rgb_pixel_t pixel,
    output scan_pos_t  pixel_pos
);

    scan_pos_t           scan;
    disp_cfg_t           cfg;
    logic [SAMPLE_W-1:0] high_data;
    logic [SAMPLE_W-1:0] low_data;

    video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL (V_TOTAL)
    ) timing_i (
        .clk_disp(clk_disp),
        .rst_n   (rst_n),
        .scan    (scan)
    );

    // one stored sample per active line.
    column_framebuffer #(.DEPTH(V_ACTIVE)) high_fb_i (
        .clk_disp (clk_disp),
        .rst_n    (rst_n),
        .sink     (high_sample),
        .scan     (scan),
        .line_data(high_data)
    );

    column_framebuffer #(.DEPTH(V_ACTIVE)) low_fb_i (
        .clk_disp (clk_disp),
        .rst_n    (rst_n),
        .sink     (low_sample),
        .scan     (scan),
        .line_data(low_data)
    );

    waterfall_regs regs_i (
        .clk_disp(clk_disp),
        .rst_n   (rst_n),
        .wb_i    (wb_i),
        .wb_o    (wb_o),
        .cfg     (cfg)
    );

    dual_waterfall pixel_i (
        .clk_disp (clk_disp),
        .rst_n    (rst_n),
        .scan     (scan),
        .cfg      (cfg),
        .high_data(high_data),
        .low_data (low_data),
        .pixel    (pixel),
        .pixel_pos(pixel_pos)
    );

endmodule

//--- tb/waterfall_checker.sv
`timescale 1ns/1ps

module waterfall_checker
    import waterfall_pkg::*;
#(
    parameter int H_ACTIVE = 480,
    parameter int H_TOTAL  = 500,
    parameter int LINES    = 8,
    parameter int V_TOTAL  = 10
) (
    input  logic        clk_disp,
    input  logic        rst_n,
    input  sample_t     high_sample,
    input  sample_t     low_sample,
    input  wb_req_t     wb_i,
    input  wb_rsp_t     wb_o,
    input  rgb_pixel_t  pixel,
    input  scan_pos_t   pixel_pos,
    input  logic [31:0] rd_exp,
    output int          errors
);

    localparam disp_cfg_t POWER_ON = '{
        background: 24'h00f500,
        high_span:  '{left: 10'd96, right: 10'd192},
        low_span:   '{left: 10'd288, right: 10'd384},
        enable:     1'b1
    };

    logic [15:0] high_q [$];
    logic [15:0] low_q [$];
    logic [15:0] high_lines [LINES];
    logic [15:0] low_lines [LINES];
    disp_cfg_t   cfg_live;
    disp_cfg_t   cfg_d1;
    disp_cfg_t   cfg_d2;
    disp_cfg_t   frame_cfg;
    int          high_d1;
    int          high_d2;
    int          low_d1;
    int          low_d2;
    scan_pos_t   scan_now; // scan position of the current cycle, counted from reset release.
    scan_pos_t   pos_d1;
    scan_pos_t   pos_d2;
    rgb_pixel_t  exp_pixel;

    function automatic rgb_pixel_t sample_color(input logic [15:0] data);
        return '{red: data[15:8], green: 8'h00, blue: data[7:0]};
    endfunction

    function automatic scan_pos_t next_scan(input scan_pos_t pos);
        scan_pos_t nxt;
        nxt = pos;
        if (pos.h == POS_W'(H_TOTAL - 1)) begin
            nxt.h = '0;
            nxt.v = (pos.v == POS_W'(V_TOTAL - 1)) ? '0 : pos.v + 1'b1;
        end else begin
            nxt.h = pos.h + 1'b1;
        end
        nxt.active = (nxt.h < POS_W'(H_ACTIVE)) && (nxt.v < POS_W'(LINES));
        return nxt;
    endfunction

    function automatic rgb_pixel_t expected_pixel(input scan_pos_t pos);
        if (!pos.active || !frame_cfg.enable) begin
            return '0;
        end
        if (pos.h >= frame_cfg.high_span.left && pos.h < frame_cfg.high_span.right) begin
            return sample_color(high_lines[pos.v[$clog2(LINES)-1:0]]);
        end
        if (pos.h >= frame_cfg.low_span.left && pos.h < frame_cfg.low_span.right) begin
            return sample_color(low_lines[pos.v[$clog2(LINES)-1:0]]);
        end
        return frame_cfg.background;
    endfunction

    // the pixel seen now belongs to the scan position of two cycles ago.
    always @(negedge clk_disp) begin
        if (!rst_n) begin
            high_q.delete();
            low_q.delete();
            cfg_live = POWER_ON;
            cfg_d1 = POWER_ON;
            cfg_d2 = POWER_ON;
            frame_cfg = POWER_ON;
            high_d1 = 0;
            high_d2 = 0;
            low_d1 = 0;
            low_d2 = 0;
            scan_now = '{h: '0, v: '0, active: 1'b1};
            pos_d1 = '0;
            pos_d2 = '0;
            errors = 0;
        end else begin
            if (wb_o.ack && wb_i.we) begin
                case (wb_i.adr)
                    REG_BG:        cfg_live.background = wb_i.dat[23:0];
                    REG_HIGH_SPAN: cfg_live.high_span = wb_i.dat[19:0];
                    REG_LOW_SPAN:  cfg_live.low_span = wb_i.dat[19:0];
                    REG_CTRL:      cfg_live.enable = wb_i.dat[0];
                    default:       ;
                endcase
            end else if (wb_o.ack && wb_o.dat !== rd_exp) begin
                $display("Mismatch wb_o.dat at adr %0h: expected %08h, got %08h",
                         wb_i.adr, rd_exp, wb_o.dat);
                errors++;
            end
            if (pixel_pos !== pos_d2) begin
                $display("Mismatch pixel_pos: expected %06h, got %06h", pos_d2, pixel_pos);
                errors++;
            end
            if (pos_d2.h == '0 && pos_d2.v == '0) begin
                frame_cfg = cfg_d2;
                for (int v = 0; v < LINES; v++) begin
                    high_lines[v] = (high_d2 + v >= LINES) ? high_q[high_d2 + v - LINES] : '0;
                    low_lines[v] = (low_d2 + v >= LINES) ? low_q[low_d2 + v - LINES] : '0;
                end
            end
            exp_pixel = expected_pixel(pos_d2);
            if (pixel !== exp_pixel) begin
                $display("Mismatch pixel at h %0d v %0d: expected %06h, got %06h",
                         pos_d2.h, pos_d2.v, exp_pixel, pixel);
                errors++;
            end
            pos_d2 = pos_d1;
            pos_d1 = scan_now;
            scan_now = next_scan(scan_now);
            cfg_d2 = cfg_d1;
            cfg_d1 = cfg_live;
            high_d2 = high_d1;
            high_d1 = high_q.size();
            low_d2 = low_d1;
            low_d1 = low_q.size();
            if (high_sample.valid) high_q.push_back(high_sample.data); // stored at the cycle end.
            if (low_sample.valid) low_q.push_back(low_sample.data);
        end
    end

endmodule

//--- tb/waterfall_properties.sv
`timescale 1ns/1ps

module waterfall_properties
    import waterfall_pkg::*;
(
    input logic       clk_disp,
    input logic       rst_n,
    input wb_req_t    wb_i,
    input wb_rsp_t    wb_o,
    input rgb_pixel_t pixel,
    input scan_pos_t  pixel_pos
);

    int failures = 0; // read by the testbench at the end of the run.

    ack_one_cycle: assert property (@(posedge clk_disp) disable iff (!rst_n)
        wb_o.ack |=> !wb_o.ack)
        else begin
            $error("ack stayed high for more than one cycle.");
            failures++;
        end

    ack_after_request: assert property (@(posedge clk_disp) disable iff (!rst_n)
        wb_o.ack |-> $past(wb_i.cyc && wb_i.stb))
        else begin
            $error("ack came without a request in the cycle before.");
            failures++;
        end

    // blanking must always be black.
    blank_is_black: assert property (@(posedge clk_disp) disable iff (!rst_n)
        !pixel_pos.active |-> (pixel == '0))
        else begin
            $error("pixel is not black outside the active area.");
            failures++;
        end

endmodule

bind waterfall_top waterfall_properties props_i (
    .clk_disp (clk_disp),
    .rst_n    (rst_n),
    .wb_i     (wb_i),
    .wb_o     (wb_o),
    .pixel    (pixel),
    .pixel_pos(pixel_pos)
);

//--- tb/waterfall_tb.sv
`timescale 1ns/1ps

module waterfall_tb;
    import waterfall_pkg::*;

    localparam int H_ACTIVE = 480;
    localparam int H_TOTAL = 500;
    localparam int V_ACTIVE = 8;
    localparam int V_TOTAL = 10;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    localparam logic [1:0] OP_WR = 2'd0;
    localparam logic [1:0] OP_RD = 2'd1;
    localparam logic [1:0] OP_PUSH = 2'd2;
    localparam logic [1:0] OP_WAIT = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [3:0]  sel;    // register address, or channel 0 high and 1 low.
        logic [31:0] data;   // write word, sample count or frame count.
        logic [31:0] rd_exp;
    } step_t;

    localparam int NSTEPS = 22;
    localparam step_t STEPS [NSTEPS] = '{
        '{OP_WAIT, 4'd0, 32'd2, 32'd0},
        '{OP_RD, REG_BG, 32'd0, 32'h0000f500},
        '{OP_RD, REG_HIGH_SPAN, 32'd0, 32'h000180c0},
        '{OP_RD, REG_CTRL, 32'd0, 32'h00000001},
        '{OP_PUSH, 4'd0, 32'd5, 32'd0},
        '{OP_PUSH, 4'd1, 32'd11, 32'd0},
        '{OP_WAIT, 4'd0, 32'd2, 32'd0},
        '{OP_WR, REG_BG, 32'h00123456, 32'd0},
        '{OP_RD, REG_BG, 32'd0, 32'h00123456},
        '{OP_WR, REG_HIGH_SPAN, 32'h0000a078, 32'd0},
        '{OP_RD, REG_HIGH_SPAN, 32'd0, 32'h0000a078},
        '{OP_WR, REG_LOW_SPAN, 32'h000190c8, 32'd0},
        '{OP_RD, REG_LOW_SPAN, 32'd0, 32'h000190c8},
        '{OP_RD, 4'd9, 32'd0, 32'd0},
        '{OP_PUSH, 4'd0, 32'd9, 32'd0},
        '{OP_WAIT, 4'd0, 32'd2, 32'd0},
        '{OP_WR, REG_CTRL, 32'd0, 32'd0},
        '{OP_RD, REG_CTRL, 32'd0, 32'd0},
        '{OP_WAIT, 4'd0, 32'd2, 32'd0},
        '{OP_WR, REG_CTRL, 32'd1, 32'd0},
        '{OP_PUSH, 4'd1, 32'd3, 32'd0},
        '{OP_WAIT, 4'd0, 32'd2, 32'd0}
    };

    logic        clk_disp;
    logic        rst_n;
    sample_t     high_sample;
    sample_t     low_sample;
    wb_req_t     wb_i;
    wb_rsp_t     wb_o;
    rgb_pixel_t  pixel;
    scan_pos_t   pixel_pos;
    logic [31:0] rd_exp;
    int          errors;

    waterfall_top #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL (V_TOTAL)
    ) dut_i (
        .clk_disp   (clk_disp),
        .rst_n      (rst_n),
        .high_sample(high_sample),
        .low_sample (low_sample),
        .wb_i       (wb_i),
        .wb_o       (wb_o),
        .pixel      (pixel),
        .pixel_pos  (pixel_pos)
    );

    waterfall_checker #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .LINES   (V_ACTIVE),
        .V_TOTAL (V_TOTAL)
    ) chk_i (
        .clk_disp   (clk_disp),
        .rst_n      (rst_n),
        .high_sample(high_sample),
        .low_sample (low_sample),
        .wb_i       (wb_i),
        .wb_o       (wb_o),
        .pixel      (pixel),
        .pixel_pos  (pixel_pos),
        .rd_exp     (rd_exp),
        .errors     (errors)
    );

    function automatic longint watchdog_ns();
        longint frames;
        frames = 2;
        foreach (STEPS[i]) begin
            if (STEPS[i].op == OP_WAIT) frames += STEPS[i].data;
        end
        return frames * FRAME_CYCLES * 10;
    endfunction

    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                             input logic [31:0] read_value);
        @(posedge clk_disp);
        #1;
        rd_exp = read_value;
        wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do @(negedge clk_disp); while (!wb_o.ack);
        @(posedge clk_disp);
        #1;
        wb_i = '0; // stb drops once ack has been seen.
    endtask

    task automatic push_samples(input logic channel, input int count);
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            @(posedge clk_disp);
            #1;
            word = $urandom;
            if (channel == 1'b0) high_sample = '{valid: 1'b1, data: word[15:0]};
            else low_sample = '{valid: 1'b1, data: word[15:0]};
        end
        @(posedge clk_disp);
        #1;
        high_sample = '0;
        low_sample = '0;
    endtask

    // a frame begins when the first active pixel leaves the pixel stage.
    task automatic wait_frames(input int count);
        for (int i = 0; i < count; i++) begin
            do @(negedge clk_disp);
            while (!(pixel_pos.active && pixel_pos.h == '0 && pixel_pos.v == '0));
        end
    endtask

    initial begin
        clk_disp = 1'b0;
        forever #5 clk_disp = ~clk_disp;
    end

    initial begin
        #(watchdog_ns());
        $display("timeout: the stimulus table did not finish in the allowed time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(37524));
        rst_n = 1'b0;
        high_sample = '0;
        low_sample = '0;
        wb_i = '0;
        rd_exp = '0;
        repeat (2) @(posedge clk_disp);
        #1;
        rst_n = 1'b1;
        foreach (STEPS[i]) begin
            case (STEPS[i].op)
                OP_WR:   bus_cycle(1'b1, STEPS[i].sel, STEPS[i].data, '0);
                OP_RD:   bus_cycle(1'b0, STEPS[i].sel, '0, STEPS[i].rd_exp);
                OP_PUSH: push_samples(STEPS[i].sel[0], STEPS[i].data);
                default: wait_frames(STEPS[i].data);
            endcase
        end
        $display("checker errors %0d, assertion failures %0d", errors, dut_i.props_i.failures);
        if (errors == 0 && dut_i.props_i.failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
